//--- Bender.yml
package:
  name: iob_apb_timer

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/iob_apb_pkg.sv
      - source/iob2apb.sv
      - source/apb_timer_regs.sv
      - source/timer_counter.sv
      - source/iob_apb_timer_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_iob_apb_timer.sv

//--- compile.f
+incdir+source
source/iob_apb_pkg.sv
source/iob2apb.sv
source/apb_timer_regs.sv
source/timer_counter.sv
source/iob_apb_timer_top.sv
testbench/tb_iob_apb_timer.sv

//--- source/apb_timer_regs.sv
`timescale 1ns/1ps

`include "iob_apb_consts.svh"

`default_nettype none

module apb_timer_regs
   import iob_apb_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  apb_req_t  apb_req_i,
   output apb_rsp_t  apb_rsp_o,
   output tmr_cmd_t  tmr_cmd_o,
   input  tmr_stat_t tmr_stat_i,
   output logic      irq_o
);

   logic sel_ctrl;
   logic sel_load;
   logic sel_count;
   logic access;
   logic wr_access;
   logic ctrl_we;

   tmr_ctrl_u ctrl_wr;  // Incoming write word
   tmr_ctrl_u ctrl_rd;  // Outgoing read word

   logic enable_q;
   logic reload_en_q;
   logic irq_en_q;
   logic restart_q;
   logic clear_irq_q;
   logic [`IOB_APB_DATA_W-1:0] load_q;
   logic [`IOB_APB_DATA_W-1:0] rdata;

   assign sel_ctrl  = (apb_req_i.addr == `TMR_CTRL_OFS);
   assign sel_load  = (apb_req_i.addr == `TMR_LOAD_OFS);
   assign sel_count = (apb_req_i.addr == `TMR_COUNT_OFS);

   assign access    = apb_req_i.sel && apb_req_i.enable;
   assign wr_access = access && apb_req_i.write;
   assign ctrl_we   = wr_access && sel_ctrl && apb_req_i.wstrb[0];  // All CTRL bits in byte 0

   assign ctrl_wr   = apb_req_i.wdata;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         enable_q    <= 1'b0;
         reload_en_q <= 1'b0;
         irq_en_q    <= 1'b0;
         restart_q   <= 1'b0;
         clear_irq_q <= 1'b0;
         load_q      <= '0;
      end else begin
         restart_q   <= ctrl_we && ctrl_wr.wr.restart;
         clear_irq_q <= ctrl_we && ctrl_wr.wr.clear_irq;
         if (ctrl_we) begin
            enable_q    <= ctrl_wr.wr.enable;
            reload_en_q <= ctrl_wr.wr.reload_en;
            irq_en_q    <= ctrl_wr.wr.irq_en;
         end
         if (wr_access && sel_load) begin
            for (int b = 0; b < `IOB_APB_STRB_W; b++) begin
               if (apb_req_i.wstrb[b]) begin
                  load_q[8*b +: 8] <= apb_req_i.wdata[8*b +: 8];
               end
            end
         end
      end
   end

   always_comb begin
      ctrl_rd                = '0;
      ctrl_rd.rd.enable      = enable_q;
      ctrl_rd.rd.reload_en   = reload_en_q;
      ctrl_rd.rd.irq_en      = irq_en_q;
      ctrl_rd.rd.irq_pending = tmr_stat_i.irq_pending;
      ctrl_rd.rd.running     = tmr_stat_i.running;
   end

   // Read mux, unmapped offsets give zero
   always_comb begin
      rdata = '0;
      if (sel_ctrl) begin
         rdata = ctrl_rd;
      end else if (sel_load) begin
         rdata = load_q;
      end else if (sel_count) begin
         rdata = tmr_stat_i.count;
      end
   end

   assign apb_rsp_o = '{ready: access, rdata: rdata};  // Zero wait states

   assign tmr_cmd_o = '{enable: enable_q, reload_en: reload_en_q, restart: restart_q,
                        clear_irq: clear_irq_q, load: load_q};

   assign irq_o = tmr_stat_i.irq_pending && irq_en_q;

   // Bridge never issues two access phases back to back
   a_pulses_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (restart_q || clear_irq_q) |=> !(restart_q || clear_irq_q));

endmodule

`default_nettype wire

//--- source/iob2apb.sv
`timescale 1ns/1ps

`include "iob_apb_consts.svh"

`default_nettype none

module iob2apb
   import iob_apb_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  iob_req_t iob_req_i,
   output iob_rsp_t iob_rsp_o,
   output apb_req_t apb_req_o,
   input  apb_rsp_t apb_rsp_i
);

   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_SETUP  = 2'd1;
   localparam logic [1:0] ST_ACCESS = 2'd2;

   logic [1:0] state_q;

   // Registered bus outputs
   logic       sel_q;
   logic       enable_q;
   logic       write_q;
   logic       ready_q;
   logic       rvalid_q;
   logic [`IOB_APB_ADDR_W-1:0] addr_q;
   logic [`IOB_APB_STRB_W-1:0] wstrb_q;
   logic [`IOB_APB_DATA_W-1:0] wdata_q;
   logic [`IOB_APB_DATA_W-1:0] rdata_q;

   logic accept;
   logic done;

   assign accept = (state_q == ST_IDLE) && iob_req_i.avalid && ready_q;
   assign done   = (state_q == ST_ACCESS) && apb_rsp_i.ready;  // pready counts only here

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= ST_IDLE;
         sel_q    <= 1'b0;
         enable_q <= 1'b0;
         write_q  <= 1'b0;
         ready_q  <= 1'b1;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  sel_q   <= 1'b1;
                  write_q <= |iob_req_i.wstrb;
                  ready_q <= 1'b0;  // Hold off the next request
                  state_q <= ST_SETUP;
               end
            end
            ST_SETUP: begin
               enable_q <= 1'b1;
               state_q  <= ST_ACCESS;
            end
            ST_ACCESS: begin
               if (done) begin
                  sel_q    <= 1'b0;
                  enable_q <= 1'b0;
                  ready_q  <= 1'b1;
                  rvalid_q <= 1'b1;
                  state_q  <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Request payload and response data
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= iob_req_i.addr;
         wstrb_q <= iob_req_i.wstrb;
         wdata_q <= iob_req_i.wdata;
      end
      if (done) begin
         rdata_q <= apb_rsp_i.rdata;
      end
   end

   assign apb_req_o = '{sel: sel_q, enable: enable_q, addr: addr_q, write: write_q,
                        wstrb: wstrb_q, wdata: wdata_q};
   assign iob_rsp_o = '{ready: ready_q, rvalid: rvalid_q, rdata: rdata_q};

   // Access phase only ever follows a setup phase
   a_enable_after_setup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      apb_req_o.enable |-> apb_req_o.sel && ($rose(apb_req_o.enable) -> $past(apb_req_o.sel)));

   a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      apb_req_o.sel && !$rose(apb_req_o.sel) |->
         $stable(apb_req_o.addr) && $stable(apb_req_o.write) &&
         $stable(apb_req_o.wstrb) && $stable(apb_req_o.wdata));

endmodule

`default_nettype wire

//--- source/iob_apb_consts.svh
`ifndef IOB_APB_CONSTS_SVH
`define IOB_APB_CONSTS_SVH

`default_nettype none

// Bus widths
`define IOB_APB_ADDR_W 32
`define IOB_APB_DATA_W 32
`define IOB_APB_STRB_W 4

// Timer register map
`define TMR_CTRL_OFS  32'h0000_0000
`define TMR_LOAD_OFS  32'h0000_0004
`define TMR_COUNT_OFS 32'h0000_0008

// Cycles from IOb acceptance to rvalid with a zero-wait APB slave
`define IOB_APB_LATENCY 3

`default_nettype wire

`endif

//--- source/iob_apb_pkg.sv
`include "iob_apb_consts.svh"

`default_nettype none

package iob_apb_pkg;

   typedef struct packed {
      logic                         avalid;
      logic [`IOB_APB_ADDR_W-1:0]   addr;
      logic [`IOB_APB_DATA_W-1:0]   wdata;
      logic [`IOB_APB_STRB_W-1:0]   wstrb;  // Zero means read
   } iob_req_t;

   typedef struct packed {
      logic                         ready;
      logic                         rvalid;  // Also marks write completion
      logic [`IOB_APB_DATA_W-1:0]   rdata;
   } iob_rsp_t;

   typedef struct packed {
      logic                         sel;
      logic                         enable;
      logic [`IOB_APB_ADDR_W-1:0]   addr;
      logic                         write;
      logic [`IOB_APB_STRB_W-1:0]   wstrb;
      logic [`IOB_APB_DATA_W-1:0]   wdata;
   } apb_req_t;

   typedef struct packed {
      logic                         ready;
      logic [`IOB_APB_DATA_W-1:0]   rdata;
   } apb_rsp_t;

   // CTRL as written by software
   typedef struct packed {
      logic [26:0] rsvd;
      logic        restart;    // Self-clearing
      logic        clear_irq;  // Self-clearing
      logic        irq_en;
      logic        reload_en;
      logic        enable;
   } tmr_ctrl_wr_t;

   // CTRL as read back, with status in place of the pulse bits
   typedef struct packed {
      logic [26:0] rsvd;
      logic        running;
      logic        irq_pending;
      logic        irq_en;
      logic        reload_en;
      logic        enable;
   } tmr_ctrl_rd_t;

   typedef union packed {
      tmr_ctrl_wr_t wr;
      tmr_ctrl_rd_t rd;
   } tmr_ctrl_u;

   typedef struct packed {
      logic                         enable;
      logic                         reload_en;
      logic                         restart;
      logic                         clear_irq;
      logic [`IOB_APB_DATA_W-1:0]   load;
   } tmr_cmd_t;

   typedef struct packed {
      logic                         running;
      logic                         irq_pending;
      logic [`IOB_APB_DATA_W-1:0]   count;
   } tmr_stat_t;

endpackage

`default_nettype wire

//--- source/iob_apb_timer_top.sv
`timescale 1ns/1ps

`include "iob_apb_consts.svh"

`default_nettype none

module iob_apb_timer_top
   import iob_apb_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  iob_req_t iob_req_i,
   output iob_rsp_t iob_rsp_o,
   output logic     irq_o
);

   apb_req_t  apb_req;
   apb_rsp_t  apb_rsp;
   tmr_cmd_t  tmr_cmd;
   tmr_stat_t tmr_stat;

   iob2apb u_bridge (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .iob_req_i (iob_req_i),
      .iob_rsp_o (iob_rsp_o),
      .apb_req_o (apb_req),
      .apb_rsp_i (apb_rsp)
   );

   apb_timer_regs u_regs (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .apb_req_i  (apb_req),
      .apb_rsp_o  (apb_rsp),
      .tmr_cmd_o  (tmr_cmd),
      .tmr_stat_i (tmr_stat),
      .irq_o      (irq_o)
   );

   timer_counter u_timer (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .tmr_cmd_i  (tmr_cmd),
      .tmr_stat_o (tmr_stat)
   );

   // Fixed round trip with the zero-wait register slave
   a_round_trip: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      iob_req_i.avalid && iob_rsp_o.ready |=>
         (!iob_rsp_o.ready) [*(`IOB_APB_LATENCY - 1)] ##1
         (iob_rsp_o.rvalid && iob_rsp_o.ready));

endmodule

`default_nettype wire

//--- source/timer_counter.sv
`timescale 1ns/1ps

`include "iob_apb_consts.svh"

`default_nettype none

module timer_counter
   import iob_apb_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  tmr_cmd_t  tmr_cmd_i,
   output tmr_stat_t tmr_stat_o
);

   logic [`IOB_APB_DATA_W-1:0] count_q;
   logic running_q;
   logic irq_pending_q;
   logic active;
   logic at_zero;
   logic expire;

   assign active  = running_q && tmr_cmd_i.enable && !tmr_cmd_i.restart;
   assign at_zero = (count_q == '0);
   assign expire  = active && (count_q == 1);  // Count reaches zero on this edge

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q       <= '0;
         running_q     <= 1'b0;
         irq_pending_q <= 1'b0;
      end else begin
         if (tmr_cmd_i.restart) begin
            count_q   <= tmr_cmd_i.load;
            running_q <= 1'b1;
         end else if (active) begin
            if (!at_zero) begin
               count_q <= count_q - 1'b1;
            end else if (tmr_cmd_i.reload_en) begin
               count_q <= tmr_cmd_i.load;  // Auto-reload
            end else begin
               running_q <= 1'b0;          // One-shot done
            end
         end

         if (expire) begin
            irq_pending_q <= 1'b1;  // Wins over a clear on the same edge
         end else if (tmr_cmd_i.clear_irq) begin
            irq_pending_q <= 1'b0;
         end
      end
   end

   assign tmr_stat_o = '{running: running_q, irq_pending: irq_pending_q, count: count_q};

   a_expire_while_running: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(irq_pending_q) |-> $past(running_q));

endmodule

`default_nettype wire

//--- testbench/tb_iob_apb_timer.sv
`timescale 1ns/1ps

`include "iob_apb_consts.svh"

`default_nettype none

module tb_iob_apb_timer
   import iob_apb_pkg::*;
();

   localparam int MAX_CYCLES = 3000;  // Directed sequence runs a few hundred cycles

   // CTRL write view
   localparam logic [31:0] CTRL_ENABLE    = 32'h01;
   localparam logic [31:0] CTRL_RELOAD_EN = 32'h02;
   localparam logic [31:0] CTRL_IRQ_EN    = 32'h04;
   localparam logic [31:0] CTRL_CLEAR_IRQ = 32'h08;
   localparam logic [31:0] CTRL_RESTART   = 32'h10;
   // CTRL read view, status in the pulse positions
   localparam logic [31:0] STAT_IRQ_PEND  = 32'h08;
   localparam logic [31:0] STAT_RUNNING   = 32'h10;

   logic     clk;
   logic     arst_n;
   iob_req_t req;
   iob_rsp_t rsp;
   logic     irq;

   int errors;
   int xfers;
   int cycles;

   iob_apb_timer_top DUT (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .iob_req_i (req),
      .iob_rsp_o (rsp),
      .irq_o     (irq)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Guard against a stalled handshake
   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: no end of test after %0d clock cycles", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("ERR @%0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // One IOb request, with handshake timing checked on every transfer
   task automatic iob_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb, output logic [31:0] rdata);
      int   k;
      logic seen;
      @(posedge clk);
      #1;
      req.avalid = 1'b1;
      req.addr   = addr;
      req.wdata  = wdata;
      req.wstrb  = wstrb;
      @(negedge clk);
      while (!rsp.ready) @(negedge clk);
      @(posedge clk);  // Accepting edge
      #1;
      req  = '0;
      k    = 0;
      seen = 1'b0;
      while (!seen) begin
         @(negedge clk);
         k++;
         if (rsp.rvalid) begin
            seen = 1'b1;
         end else if (rsp.ready) begin
            report_mismatch("ready while busy", 32'd1, 32'd0);
         end
      end
      if (k != `IOB_APB_LATENCY) report_mismatch("rvalid latency", k, `IOB_APB_LATENCY);
      if (!rsp.ready) report_mismatch("ready with rvalid", 32'd0, 32'd1);
      rdata = rsp.rdata;
      @(negedge clk);
      if (rsp.rvalid) report_mismatch("rvalid length", 32'd2, 32'd1);
      xfers++;
   endtask

   task automatic iob_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
      logic [31:0] unused;
      iob_transfer(addr, wdata, wstrb, unused);
   endtask

   task automatic iob_read(input logic [31:0] addr, output logic [31:0] rdata);
      iob_transfer(addr, 32'h0, 4'h0, rdata);
   endtask

   task automatic reset_defaults();
      logic [31:0] d;
      @(negedge clk);
      if (rsp.ready !== 1'b1) report_mismatch("ready after reset", rsp.ready, 32'd1);
      if (rsp.rvalid !== 1'b0) report_mismatch("rvalid after reset", rsp.rvalid, 32'd0);
      if (irq !== 1'b0) report_mismatch("irq after reset", irq, 32'd0);
      iob_read(`TMR_CTRL_OFS, d);
      if (d !== 32'h0) report_mismatch("CTRL after reset", d, 32'h0);
      iob_read(`TMR_LOAD_OFS, d);
      if (d !== 32'h0) report_mismatch("LOAD after reset", d, 32'h0);
      iob_read(`TMR_COUNT_OFS, d);
      if (d !== 32'h0) report_mismatch("COUNT after reset", d, 32'h0);
   endtask

   task automatic bus_timing();
      logic [31:0] d;
      iob_write(`TMR_LOAD_OFS, 32'h1234_5678, 4'hf);
      iob_read(`TMR_LOAD_OFS, d);
      if (d !== 32'h1234_5678) report_mismatch("LOAD readback", d, 32'h1234_5678);
      iob_read(32'h0000_000c, d);
      if (d !== 32'h0) report_mismatch("unmapped 0xc", d, 32'h0);
      iob_read(32'h0000_0040, d);
      if (d !== 32'h0) report_mismatch("unmapped 0x40", d, 32'h0);
   endtask

   task automatic load_lane_merge();
      logic [31:0] first;
      logic [31:0] second;
      logic [31:0] exp;
      logic [31:0] d;
      logic [3:0]  strb;
      int unsigned r;
      first  = $urandom;
      second = $urandom;
      r      = ($urandom % 14) + 1;  // Partial and nonzero
      strb   = r[3:0];
      iob_write(`TMR_LOAD_OFS, first, 4'hf);
      iob_write(`TMR_LOAD_OFS, second, strb);
      exp = first;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) exp[8*b +: 8] = second[8*b +: 8];
      end
      iob_read(`TMR_LOAD_OFS, d);
      if (d !== exp) report_mismatch("LOAD lane merge", d, exp);
   endtask

   task automatic one_shot_irq();
      logic [31:0] d;
      iob_write(`TMR_LOAD_OFS, 32'd20, 4'hf);
      iob_write(`TMR_CTRL_OFS, CTRL_ENABLE | CTRL_IRQ_EN | CTRL_RESTART, 4'hf);
      wait_cycles(40);
      if (irq !== 1'b1) report_mismatch("irq after expiry", irq, 32'd1);
      iob_read(`TMR_COUNT_OFS, d);
      if (d !== 32'h0) report_mismatch("one-shot COUNT", d, 32'h0);
      iob_read(`TMR_CTRL_OFS, d);
      if (d !== (CTRL_ENABLE | CTRL_IRQ_EN | STAT_IRQ_PEND))
         report_mismatch("one-shot CTRL", d, CTRL_ENABLE | CTRL_IRQ_EN | STAT_IRQ_PEND);
      iob_write(`TMR_CTRL_OFS, CTRL_ENABLE | CTRL_IRQ_EN | CTRL_CLEAR_IRQ, 4'hf);
      iob_read(`TMR_CTRL_OFS, d);
      if (d !== (CTRL_ENABLE | CTRL_IRQ_EN))
         report_mismatch("CTRL after clear", d, CTRL_ENABLE | CTRL_IRQ_EN);
      if (irq !== 1'b0) report_mismatch("irq after clear", irq, 32'd0);
   endtask

   task automatic masked_irq();
      logic [31:0] d;
      iob_write(`TMR_CTRL_OFS, CTRL_ENABLE | CTRL_RESTART, 4'hf);
      wait_cycles(40);
      if (irq !== 1'b0) report_mismatch("masked irq", irq, 32'd0);
      iob_read(`TMR_CTRL_OFS, d);
      if (d !== (CTRL_ENABLE | STAT_IRQ_PEND))
         report_mismatch("masked CTRL", d, CTRL_ENABLE | STAT_IRQ_PEND);
      iob_write(`TMR_CTRL_OFS, CTRL_CLEAR_IRQ, 4'hf);
   endtask

   task automatic auto_reload();
      logic [31:0] d;
      logic [31:0] exp;
      exp = CTRL_ENABLE | CTRL_RELOAD_EN | STAT_IRQ_PEND | STAT_RUNNING;
      iob_write(`TMR_LOAD_OFS, 32'd10, 4'hf);
      iob_write(`TMR_CTRL_OFS, CTRL_ENABLE | CTRL_RELOAD_EN | CTRL_RESTART, 4'hf);
      wait_cycles(50);
      iob_read(`TMR_CTRL_OFS, d);
      if (d !== exp) report_mismatch("reload CTRL", d, exp);
      iob_read(`TMR_COUNT_OFS, d);
      if ($isunknown(d) || d > 32'd10) report_mismatch("reload COUNT above LOAD", d, 32'd10);
      if (irq !== 1'b0) report_mismatch("reload irq", irq, 32'd0);
      iob_write(`TMR_CTRL_OFS, CTRL_CLEAR_IRQ, 4'hf);  // Stop and clear
   endtask

   initial begin
      errors = 0;
      xfers  = 0;
      cycles = 0;
      req    = '0;
      arst_n = 1'b0;
      void'($urandom(32'hf538));
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;

      reset_defaults();
      bus_timing();
      load_lane_merge();
      one_shot_irq();
      masked_irq();
      auto_reload();

      $display("%0d transfers, %0d errors", xfers, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
